// ==== hw/modmul_consts.svh ====
`ifndef MODMUL_CONSTS_SVH
`define MODMUL_CONSTS_SVH

// operand and modulus width
`define MODMUL_OPW    32
`define MODMUL_PRODW  64

// signed fold sum, extra bits so fermat sums can go negative
`define MODMUL_ACCW   40

`define MODMUL_BL_W   6
`define MODMUL_MIN_BL 3   // smallest supported k
`define MODMUL_MAX_BL 31  // largest supported k

`endif

// ==== hw/modmul_pkg.sv ====
`include "modmul_consts.svh"

package modmul_pkg;

  typedef logic [`MODMUL_OPW-1:0]         operand_t;
  typedef logic [`MODMUL_PRODW-1:0]       product_t;
  typedef logic signed [`MODMUL_ACCW-1:0] acc_t;
  typedef logic [`MODMUL_BL_W-1:0]        bitlen_t;

  typedef enum logic [1:0] {
    MOD_NONE,
    MOD_MERSENNE,  // 2^k - 1
    MOD_FERMAT     // 2^(k-1) + 1
  } mod_kind_e;

  typedef struct packed {
    mod_kind_e kind;
    bitlen_t   width;  // fold chunk width, k or k-1
    operand_t  mask;   // 2^width - 1
  } mod_info_t;

  typedef enum logic {MUL_IDLE, MUL_RUN} mul_state_e;

  typedef enum logic [1:0] {RED_IDLE, RED_FOLD, RED_CORRECT, RED_DONE} red_state_e;

  typedef enum logic [1:0] {TOP_IDLE, TOP_MUL, TOP_RED, TOP_DONE} top_state_e;

endpackage

// ==== hw/modulus_classifier.sv ====
`include "modmul_consts.svh"

module modulus_classifier (
  input  modmul_pkg::operand_t  m_i,
  output modmul_pkg::mod_info_t info_o
);

  import modmul_pkg::*;

  bitlen_t              k;
  bitlen_t              width;
  logic [`MODMUL_OPW:0] ones_k;    // 2^k - 1, one bit wider so k=32 fits
  logic [`MODMUL_OPW:0] fermat_k;  // 2^(k-1) + 1
  logic                 in_range;
  logic                 is_mersenne;
  logic                 is_fermat;
  mod_kind_e            kind;

  // leading-one scan, the last hit is the highest set bit
  always_comb begin
    k = '0;
    for (int i = 0; i < `MODMUL_OPW; i++) begin
      if (m_i[i]) begin
        k = bitlen_t'(i + 1);
      end
    end
  end

  assign ones_k   = ((`MODMUL_OPW+1)'(1) << k) - 1'b1;
  assign fermat_k = ((`MODMUL_OPW+1)'(1) << (k - 1'b1)) | (`MODMUL_OPW+1)'(1);

  assign in_range    = (k >= `MODMUL_MIN_BL) && (k <= `MODMUL_MAX_BL);
  assign is_mersenne = ({1'b0, m_i} == ones_k);
  assign is_fermat   = ({1'b0, m_i} == fermat_k);

  // m = 3 matches both forms, mersenne wins
  assign kind = !in_range   ? MOD_NONE     :
                is_mersenne ? MOD_MERSENNE :
                is_fermat   ? MOD_FERMAT   : MOD_NONE;

  assign width = (kind == MOD_FERMAT) ? k - 1'b1 : k;

  assign info_o.kind  = kind;
  assign info_o.width = (kind == MOD_NONE) ? '0 : width;
  assign info_o.mask  = (kind == MOD_NONE) ? '0 : operand_t'((64'd1 << width) - 1'b1);

endmodule

// ==== hw/shiftadd_multiplier.sv ====
`include "modmul_consts.svh"

module shiftadd_multiplier (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  modmul_pkg::operand_t a_i,
  input  modmul_pkg::operand_t b_i,
  output modmul_pkg::product_t product_o,
  output logic                 done_o
);

  import modmul_pkg::*;

  localparam int CNT_W = $clog2(`MODMUL_OPW);

  mul_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             load;
  logic             last;
  operand_t         mplier_q;  // shifts right, bit 0 picks the add
  product_t         mcand_q;   // shifts left
  product_t         acc_q;

  assign load = (state_q == MUL_IDLE) && start_i;
  assign last = (cnt_q == CNT_W'(`MODMUL_OPW - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        MUL_IDLE: begin
          if (start_i) begin
            state_q <= MUL_RUN;
            cnt_q   <= '0;
          end
        end
        MUL_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (last) begin
            state_q <= MUL_IDLE;
            done_o  <= 1'b1;  // lines up with the final add
          end
        end
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  // one multiplier bit per cycle
  always_ff @(posedge clk_i) begin
    if (load) begin
      mplier_q <= b_i;
      mcand_q  <= product_t'(a_i);
      acc_q    <= '0;
    end else if (state_q == MUL_RUN) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mplier_q <= mplier_q >> 1;
      mcand_q  <= mcand_q << 1;
    end
  end

  assign product_o = acc_q;  // stays put until the next start

endmodule

// ==== hw/fold_reducer.sv ====
module fold_reducer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  modmul_pkg::product_t  product_i,
  input  modmul_pkg::operand_t  m_i,
  input  modmul_pkg::mod_info_t info_i,
  output modmul_pkg::operand_t  result_o,
  output logic                  done_o
);

  import modmul_pkg::*;

  red_state_e state_q;
  logic       load;
  logic       sub_q;      // next fermat chunk is subtracted
  acc_t       acc_q;
  product_t   rem_q;      // high part still to be folded
  product_t   prod_hi;
  product_t   rem_next;
  operand_t   chunk;
  acc_t       chunk_ext;
  acc_t       m_ext;
  acc_t       acc_fold;
  logic       is_fermat;
  logic       too_low;
  logic       too_high;

  assign load      = (state_q == RED_IDLE) && start_i;
  assign is_fermat = (info_i.kind == MOD_FERMAT);

  assign prod_hi  = product_i >> info_i.width;
  assign rem_next = rem_q >> info_i.width;

  assign chunk     = operand_t'(rem_q) & info_i.mask;
  assign chunk_ext = acc_t'(chunk);  // zero extended
  assign m_ext     = acc_t'(m_i);

  // 2^k = 1 mod m for mersenne, 2^(k-1) = -1 mod m for fermat
  assign acc_fold = (is_fermat && sub_q) ? acc_q - chunk_ext : acc_q + chunk_ext;

  assign too_low  = (acc_q < 0);
  assign too_high = (acc_q >= m_ext);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RED_IDLE;
      sub_q   <= 1'b0;
    end else begin
      case (state_q)
        RED_IDLE: begin
          if (start_i) begin
            sub_q <= 1'b1;  // first high chunk has weight -1
            if (prod_hi == '0) begin
              state_q <= RED_CORRECT;
            end else begin
              state_q <= RED_FOLD;
            end
          end
        end
        RED_FOLD: begin
          sub_q <= ~sub_q;
          if (rem_next == '0) begin
            state_q <= RED_CORRECT;
          end
        end
        RED_CORRECT: begin
          if (!too_low && !too_high) begin
            state_q <= RED_DONE;
          end
        end
        RED_DONE: state_q <= RED_IDLE;
        default:  state_q <= RED_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      acc_q <= acc_t'(operand_t'(product_i) & info_i.mask);
      rem_q <= prod_hi;
    end else if (state_q == RED_FOLD) begin
      acc_q <= acc_fold;
      rem_q <= rem_next;
    end else if (state_q == RED_CORRECT) begin
      // one add or subtract of m per cycle
      if (too_low) begin
        acc_q <= acc_q + m_ext;
      end else if (too_high) begin
        acc_q <= acc_q - m_ext;
      end
    end
  end

  assign result_o = operand_t'(acc_q);  // acc is in [0, m) once done
  assign done_o   = (state_q == RED_DONE);

endmodule

// ==== hw/special_modmul.sv ====
module special_modmul (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  modmul_pkg::operand_t a_i,
  input  modmul_pkg::operand_t b_i,
  input  modmul_pkg::operand_t m_i,
  output modmul_pkg::operand_t result_o,
  output logic                 valid_o,
  output logic                 err_o,
  output logic                 busy_o
);

  import modmul_pkg::*;

  top_state_e state_q;
  logic       accept;
  logic       launch_q;  // first cycle after accept, classifier output is settled
  operand_t   a_q;
  operand_t   b_q;
  operand_t   m_q;
  mod_info_t  info;
  logic       mul_start;
  logic       mul_done;
  product_t   product;
  logic       red_start;
  logic       red_done;
  operand_t   red_result;

  assign accept    = (state_q == TOP_IDLE) && start_i;
  assign mul_start = (state_q == TOP_MUL) && launch_q && (info.kind != MOD_NONE);
  assign red_start = (state_q == TOP_MUL) && mul_done;
  assign busy_o    = (state_q != TOP_IDLE);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      a_q <= a_i;
      b_q <= b_i;
      m_q <= m_i;
    end
  end

  modulus_classifier i_classifier (
    .m_i    (m_q),
    .info_o (info)
  );

  shiftadd_multiplier i_mul (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (mul_start),
    .a_i       (a_q),
    .b_i       (b_q),
    .product_o (product),
    .done_o    (mul_done)
  );

  fold_reducer i_red (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (red_start),
    .product_i (product),
    .m_i       (m_q),
    .info_i    (info),
    .result_o  (red_result),
    .done_o    (red_done)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= TOP_IDLE;
      launch_q <= 1'b0;
      valid_o  <= 1'b0;
      err_o    <= 1'b0;
      result_o <= '0;
    end else begin
      // status outputs are single-cycle pulses
      launch_q <= 1'b0;
      valid_o  <= 1'b0;
      err_o    <= 1'b0;
      result_o <= '0;
      case (state_q)
        TOP_IDLE: begin
          if (accept) begin
            state_q  <= TOP_MUL;
            launch_q <= 1'b1;
          end
        end
        TOP_MUL: begin
          if (launch_q && (info.kind == MOD_NONE)) begin
            state_q <= TOP_DONE;  // unsupported m, skip both engines
            valid_o <= 1'b1;
            err_o   <= 1'b1;
          end else if (mul_done) begin
            state_q <= TOP_RED;
          end
        end
        TOP_RED: begin
          if (red_done) begin
            state_q  <= TOP_DONE;
            valid_o  <= 1'b1;
            result_o <= red_result;
          end
        end
        TOP_DONE: state_q <= TOP_IDLE;
        default:  state_q <= TOP_IDLE;
      endcase
    end
  end

endmodule

// ==== test/tb_special_modmul.sv ====
`include "modmul_consts.svh"

module tb_special_modmul;

  import modmul_pkg::*;

  localparam int N_MERS     = 40;
  localparam int N_FERM     = 40;
  localparam int N_ERR      = 30;
  localparam int N_TESTS    = N_MERS + N_FERM + N_ERR + 3;
  localparam int MAX_CYCLES = N_TESTS * (32 + 64 + 8 + 40);

  logic     clk_i;
  logic     rst_ni;
  logic     start_i;
  operand_t a_i;
  operand_t b_i;
  operand_t m_i;
  operand_t result_o;
  logic     valid_o;
  logic     err_o;
  logic     busy_o;
  integer   seed;
  int       cycle_cnt = 0;
  operand_t odd_m [6] = '{32'd0, 32'd1, 32'd2, 32'd3, 32'hffff_ffff, 32'h8000_0001};

  special_modmul i_dut (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      report_failure($sformatf("timeout, the DUT did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  task automatic report_failure(string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "%s", what);
  endtask

  task automatic check_result(string name, operand_t got, operand_t exp);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // supported only for m = 2^k - 1 or 2^(k-1) + 1 with k in range
  function automatic logic expect_err(operand_t m);
    int          k;
    logic [63:0] mm;
    k  = 0;
    mm = 64'(m);
    for (int i = 0; i < `MODMUL_OPW; i++) begin
      if (m[i]) begin
        k = i + 1;
      end
    end
    if (k < `MODMUL_MIN_BL || k > `MODMUL_MAX_BL) begin
      return 1'b1;
    end
    return !(mm == (64'd1 << k) - 64'd1 || mm == (64'd1 << (k - 1)) + 64'd1);
  endfunction

  function automatic operand_t expect_result(operand_t a, operand_t b, operand_t m);
    return operand_t'((64'(a) * 64'(b)) % 64'(m));
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // 0 and m-1 turn up now and then
  function automatic operand_t rand_operand(operand_t m);
    case (rand_range(0, 5))
      0:       return '0;
      1:       return m - 1'b1;
      default: return operand_t'({$random(seed), $random(seed)} % 64'(m));
    endcase
  endfunction

  task automatic run_case(operand_t a, operand_t b, operand_t m);
    operand_t exp_r;
    logic     exp_e;
    int       lat;
    exp_e   = expect_err(m);
    exp_r   = exp_e ? '0 : expect_result(a, b, m);
    a_i     = a;
    b_i     = b;
    m_i     = m;
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    a_i     = $random(seed);  // operands are latched by now
    b_i     = $random(seed);
    m_i     = $random(seed);
    lat     = 1;
    while (!valid_o) begin
      check_result("result_o", result_o, '0);
      check_flag("err_o", err_o, 1'b0);
      @(negedge clk_i);
      lat++;
    end
    check_flag("err_o", err_o, exp_e);
    check_result("result_o", result_o, exp_r);
    if (exp_e && lat != 2) begin
      report_failure($sformatf("error for m %h came %0d cycles after start, not 2", m, lat));
    end
    while (busy_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic check_busy_start();
    operand_t m;
    operand_t a;
    operand_t b;
    int       n_valid;
    m       = 32'd8191;
    a       = operand_t'(rand_range(1, int'(m) - 1));  // nonzero so a relatched m would show
    b       = operand_t'(rand_range(1, int'(m) - 1));
    n_valid = 0;
    a_i     = a;
    b_i     = b;
    m_i     = m;
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    repeat (4) @(negedge clk_i);
    check_flag("busy_o", busy_o, 1'b1);
    a_i     = $random(seed);
    b_i     = $random(seed);
    m_i     = 32'd31;  // supported m that would run if accepted
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    repeat (32 + 64 + 8 + 40) begin  // long enough for a stray second op
      if (valid_o) begin
        n_valid++;
        check_flag("err_o", err_o, 1'b0);
        check_result("result_o", result_o, expect_result(a, b, m));
      end
      @(negedge clk_i);
    end
    if (n_valid != 1) begin
      report_failure($sformatf("start while busy gave %0d result pulses instead of 1", n_valid));
    end
  endtask

  initial begin
    operand_t m;
    seed    = 32'he187;
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    start_i = 1'b0;
    a_i     = '0;
    b_i     = '0;
    m_i     = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("valid_o", valid_o, 1'b0);
    check_flag("err_o", err_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    check_result("result_o", result_o, '0);
    m = 32'h0001_0001;  // fermat with k = 17
    run_case(m - 1'b1, m - 1'b1, m);
    run_case('0, m - 1'b1, m);
    for (int i = 0; i < N_MERS; i++) begin
      m = operand_t'((64'd1 << rand_range(3, 31)) - 64'd1);
      run_case(rand_operand(m), rand_operand(m), m);
    end
    for (int i = 0; i < N_FERM; i++) begin
      m = operand_t'((64'd1 << (rand_range(3, 31) - 1)) + 64'd1);
      run_case(rand_operand(m), rand_operand(m), m);
    end
    for (int i = 0; i < N_ERR; i++) begin
      if (i < 6) begin
        m = odd_m[i];  // out of range special forms and tiny m
      end else begin
        m = operand_t'($random(seed)) >> rand_range(0, 28);
        while (!expect_err(m)) begin
          m = $random(seed);
        end
      end
      run_case($random(seed), $random(seed), m);
    end
    check_busy_start();
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== special_modmul.f ====
+incdir+hw
hw/modmul_pkg.sv
hw/modulus_classifier.sv
hw/shiftadd_multiplier.sv
hw/fold_reducer.sv
hw/special_modmul.sv
test/tb_special_modmul.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f special_modmul.f \
  --top-module tb_special_modmul -o sim_special_modmul \
  && ./obj_dir/sim_special_modmul | tee /dev/stderr | grep -F -x '** PASS **' > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
